/* filelist.f */
host_mem_pkg.sv
avmm_burst_map.sv
rd_rob_slots.sv
rd_rob.sv
host_mem_map.sv
host_mem_model.sv
tb_host_mem_map.sv

/* Bender.yml */
package:
  name: host_mem_map

sources:
  - host_mem_pkg.sv
  - avmm_burst_map.sv
  - rd_rob_slots.sv
  - rd_rob.sv
  - host_mem_map.sv
  - target: test
    files:
      - host_mem_model.sv
      - tb_host_mem_map.sv

/* tb_host_mem_map.sv */
// Directed testbench for the host memory read mapper.
// Drives accelerator bursts, checks every host burst against the splitting
// rule and every returned line against request order and expected data.
`timescale 1ns/1ps
`default_nettype none

module tb_host_mem_map;
    import host_mem_pkg::*;

    localparam int HOST_MAX_BURST = 4;
    localparam int NATURAL_ALIGNMENT = 1;
    localparam int PAGE_LINES = 8;
    localparam int MAX_ACTIVE_RD_LINES = 16;
    // Roughly four times the cycles all tests need together
    localparam int TIMEOUT_CYCLES = 4000;

    logic    clk;
    logic    reset;
    logic    hold;
    rd_req_t master_req;
    logic    master_read;
    logic    master_waitrequest;
    rd_rsp_t master_rsp;
    logic    master_readdatavalid;
    rd_req_t host_req;
    logic    host_read;
    logic    host_waitrequest;
    rd_rsp_t host_rsp;
    logic    host_readdatavalid;
    int      pending_lines;

    int         seed = 32'hfe2be674;
    string      cur_test;
    int         errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    int         pieces_seen = 0;
    // Slots reserved by host bursts and lines handed back since reset
    int         slots_issued = 0;
    int         lines_returned = 0;
    // Expected host pieces and expected returned lines with the oldest first
    line_addr_t exp_piece_addr [$];
    int         exp_piece_len [$];
    line_addr_t exp_lines [$];

    host_mem_map
    #(
        .HOST_MAX_BURST(HOST_MAX_BURST),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT),
        .PAGE_LINES(PAGE_LINES),
        .MAX_ACTIVE_RD_LINES(MAX_ACTIVE_RD_LINES)
    )
    i_host_mem_map
    (
        .clk(clk),
        .reset(reset),
        .master_req(master_req),
        .master_read(master_read),
        .master_waitrequest(master_waitrequest),
        .master_rsp(master_rsp),
        .master_readdatavalid(master_readdatavalid),
        .host_req(host_req),
        .host_read(host_read),
        .host_waitrequest(host_waitrequest),
        .host_rsp(host_rsp),
        .host_readdatavalid(host_readdatavalid)
    );

    host_mem_model
    #(
        .MAX_ACTIVE_RD_LINES(MAX_ACTIVE_RD_LINES)
    )
    i_host_mem_model
    (
        .clk(clk),
        .reset(reset),
        .hold(hold),
        .host_req(host_req),
        .host_read(host_read),
        .host_waitrequest(host_waitrequest),
        .host_rsp(host_rsp),
        .host_readdatavalid(host_readdatavalid),
        .pending_lines(pending_lines)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // The data the host holds at a given line address
    function automatic line_data_t line_data_of(input line_addr_t a);
        return {32'h0, a} * 64'h9e3779b97f4a7c15;
    endfunction

    // A host burst is legal if it fits the size limit, stays in one page
    // and, with alignment on, is a power of two that divides its address
    function automatic bit piece_legal(input line_addr_t a, input int len);
        if ((len < 1) || (len > HOST_MAX_BURST))
            return 1'b0;
        if ((PAGE_LINES != 0) && ((a % PAGE_LINES) + len > PAGE_LINES))
            return 1'b0;
        if ((NATURAL_ALIGNMENT != 0) && (((len & (len - 1)) != 0) || ((a % len) != 0)))
            return 1'b0;
        return 1'b1;
    endfunction

    // Find the longest legal piece by shrinking from the size limit
    function automatic int split_len(input line_addr_t a, input int r);
        int len;
        len = (r < HOST_MAX_BURST) ? r : HOST_MAX_BURST;
        while ((len > 1) && !piece_legal(a, len))
            len--;
        return len;
    endfunction

    // Record the expected pieces and lines, then hold the request until taken
    task automatic issue_burst(input line_addr_t addr, input int len);
        line_addr_t a;
        int         r;
        int         n;
        a = addr;
        r = len;
        while (r > 0)
        begin
            n = split_len(a, r);
            exp_piece_addr.push_back(a);
            exp_piece_len.push_back(n);
            a += line_addr_t'(n);
            r -= n;
        end
        for (int i = 0; i < len; i++)
            exp_lines.push_back(addr + line_addr_t'(i));
        master_req = '{address: addr, burstcount: burst_cnt_t'(len), user: '0};
        master_read = 1'b1;
        // Waitrequest settles after the rising edge, so a low value here
        // means the burst transfers on the next rising edge
        while (master_waitrequest)
            @(negedge clk);
        @(negedge clk);
        master_read = 1'b0;
    endtask

    // Wait until all expected traffic is seen, then watch for stray lines
    task automatic wait_drain();
        while ((exp_lines.size() != 0) || (exp_piece_addr.size() != 0))
            @(negedge clk);
        repeat (8) @(negedge clk);
    endtask

    task automatic end_test(input int errors_before);
        if (errors == errors_before)
        begin
            tests_passed++;
            $display("%s: ok", cur_test);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, errors - errors_before);
        end
    endtask

    // Host request log and accelerator response checks
    always @(posedge clk)
    begin
        if (!reset && host_read && !host_waitrequest)
        begin
            pieces_seen++;
            check_value({cur_test, " legal piece"}, 64'(1),
                        64'(piece_legal(host_req.address, int'(host_req.burstcount))));
            // Slot ranges are handed out back to back from slot 0 after reset
            check_value({cur_test, " piece slot"}, 64'(slots_issued % MAX_ACTIVE_RD_LINES),
                        64'(host_req.user));
            slots_issued += int'(host_req.burstcount);
            if (exp_piece_addr.size() == 0)
            begin
                $display("Error in %s: host request with no burst outstanding", cur_test);
                errors++;
            end
            else
            begin
                check_value({cur_test, " piece address"}, 64'(exp_piece_addr.pop_front()),
                            64'(host_req.address));
                check_value({cur_test, " piece length"}, 64'(exp_piece_len.pop_front()),
                            64'(host_req.burstcount));
            end
        end
        if (!reset && master_readdatavalid)
        begin
            // Lines leave the buffer slot by slot in request order
            check_value({cur_test, " line slot"}, 64'(lines_returned % MAX_ACTIVE_RD_LINES),
                        64'(master_rsp.user));
            lines_returned++;
            if (exp_lines.size() == 0)
            begin
                $display("Error in %s: response line with no line outstanding", cur_test);
                errors++;
            end
            else
            begin
                check_value({cur_test, " line data"}, line_data_of(exp_lines.pop_front()),
                            master_rsp.data);
            end
        end
        if (pending_lines > MAX_ACTIVE_RD_LINES)
        begin
            $display("Error in %s: %0d lines outstanding at the host", cur_test,
                     pending_lines);
            errors++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Error: the run timed out after %0d cycles in %s", cycles, cur_test);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic test_single_line();
        int e;
        e = errors;
        cur_test = "single_line";
        issue_burst(32'h0000_1235, 1);
        issue_burst(32'h0000_0000, 1);
        issue_burst(32'h000f_fff8, 1);
        wait_drain();
        end_test(e);
    endtask

    task automatic test_split_16();
        int e;
        int p;
        e = errors;
        p = pieces_seen;
        cur_test = "split_16";
        issue_burst(32'd6, 16);
        wait_drain();
        // Lines 6..21 split as 2, 4, 4, 4 and 2 under the page and alignment rules
        check_value({cur_test, " piece count"}, 64'(5), 64'(pieces_seen - p));
        end_test(e);
    endtask

    task automatic test_back_to_back();
        int e;
        e = errors;
        cur_test = "back_to_back";
        issue_burst(32'd100, 5);
        issue_burst(32'd37, 9);
        issue_burst(32'd0, 16);
        issue_burst(32'd255, 3);
        issue_burst(32'd64, 12);
        wait_drain();
        end_test(e);
    endtask

    task automatic test_slot_limit();
        int e;
        e = errors;
        cur_test = "slot_limit";
        hold = 1'b1;
        fork
            begin
                issue_burst(32'd64, 8);
                issue_burst(32'd72, 8);
                issue_burst(32'd80, 8);
            end
        join_none
        repeat (40) @(negedge clk);
        // With nothing answered the buffer fills and no more lines go out
        check_value({cur_test, " lines held"}, 64'(MAX_ACTIVE_RD_LINES), 64'(pending_lines));
        hold = 1'b0;
        wait fork;
        wait_drain();
        end_test(e);
    endtask

    task automatic test_random_mix();
        int         e;
        line_addr_t a;
        int         len;
        e = errors;
        cur_test = "random_mix";
        for (int i = 0; i < 40; i++)
        begin
            a = $unsigned($random(seed)) & 32'h000f_ffff;
            len = ($unsigned($random(seed)) % 16) + 1;
            issue_burst(a, len);
        end
        wait_drain();
        end_test(e);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        hold = 1'b0;
        master_req = '0;
        master_read = 1'b0;
        cur_test = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_single_line();
        test_split_16();
        test_back_to_back();
        test_slot_limit();
        test_random_mix();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if ((tests_failed == 0) && (errors == 0))
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* host_mem_model.sv */
// Host memory model for the read mapper testbench.
// Accepts tagged host bursts, holds their lines and answers them one per
// cycle in a shuffled order. Raising hold keeps every line back.
`timescale 1ns/1ps
`default_nettype none

module host_mem_model
#(
    parameter int MAX_ACTIVE_RD_LINES = 16
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hold,
    input  host_mem_pkg::rd_req_t host_req,
    input  logic                  host_read,
    output logic                  host_waitrequest,
    output host_mem_pkg::rd_rsp_t host_rsp,
    output logic                  host_readdatavalid,
    output int                    pending_lines
);
    import host_mem_pkg::*;

    // Shuffle source with a fixed seed so every run sees the same order
    int seed = 32'hfe2be674;

    // Lines accepted from the DUT and not yet answered
    line_addr_t pend_addr [$];
    rob_idx_t   pend_slot [$];

    initial
    begin
        host_waitrequest = 1'b0;
        host_rsp = '0;
        host_readdatavalid = 1'b0;
        pending_lines = 0;
    end

    // Everything toggles on the falling edge and holds through the rising edge
    always @(negedge clk)
    begin : drive_host
        int pick;
        if (reset)
        begin
            host_waitrequest = 1'b0;
            host_readdatavalid = 1'b0;
            pend_addr.delete();
            pend_slot.delete();
        end
        else
        begin
            host_readdatavalid = 1'b0;
            // Answer a random held line on about three cycles out of four
            if (!hold && (pend_addr.size() > 0) && (($random(seed) & 3) != 0))
            begin
                pick = $unsigned($random(seed)) % pend_addr.size();
                host_rsp.data = {32'h0, pend_addr[pick]} * 64'h9e3779b97f4a7c15;
                host_rsp.user = pend_slot[pick];
                host_readdatavalid = 1'b1;
                pend_addr.delete(pick);
                pend_slot.delete(pick);
            end
            // Occasional back-pressure on the request port
            host_waitrequest = (($random(seed) & 7) == 0);
            // The burst transfers on the coming rising edge, so record it now
            if (host_read && !host_waitrequest)
            begin
                for (int i = 0; i < int'(host_req.burstcount); i++)
                begin
                    pend_addr.push_back(host_req.address + line_addr_t'(i));
                    pend_slot.push_back(rob_idx_t'((host_req.user + i) % MAX_ACTIVE_RD_LINES));
                end
            end
        end
        pending_lines = pend_addr.size();
    end

endmodule

`default_nettype wire

/* host_mem_map.sv */
// Top level of the host memory read mapper.
// Accelerator bursts pass through the burst mapper and then the reorder
// buffer, which drives the host port and returns lines in request order.
`timescale 1ns/1ps
`default_nettype none

module host_mem_map
#(
    parameter int HOST_MAX_BURST = 4,
    parameter int NATURAL_ALIGNMENT = 1,
    parameter int PAGE_LINES = 8,
    parameter int MAX_ACTIVE_RD_LINES = 16
)
(
    input  logic                  clk,
    input  logic                  reset,

    // Accelerator side
    input  host_mem_pkg::rd_req_t master_req,
    input  logic                  master_read,
    output logic                  master_waitrequest,
    output host_mem_pkg::rd_rsp_t master_rsp,
    output logic                  master_readdatavalid,

    // Host memory side
    output host_mem_pkg::rd_req_t host_req,
    output logic                  host_read,
    input  logic                  host_waitrequest,
    input  host_mem_pkg::rd_rsp_t host_rsp,
    input  logic                  host_readdatavalid
);
    import host_mem_pkg::*;

    // Host-legal pieces on their way into the reorder buffer
    rd_req_t map_req;
    logic    map_read;
    logic    map_waitrequest;

    avmm_burst_map
    #(
        .HOST_MAX_BURST(HOST_MAX_BURST),
        .NATURAL_ALIGNMENT(NATURAL_ALIGNMENT),
        .PAGE_LINES(PAGE_LINES)
    )
    i_avmm_burst_map
    (
        .clk(clk),
        .reset(reset),
        .master_req(master_req),
        .master_read(master_read),
        .master_waitrequest(master_waitrequest),
        .map_req(map_req),
        .map_read(map_read),
        .map_waitrequest(map_waitrequest)
    );

    rd_rob
    #(
        .MAX_ACTIVE_RD_LINES(MAX_ACTIVE_RD_LINES)
    )
    i_rd_rob
    (
        .clk(clk),
        .reset(reset),
        .map_req(map_req),
        .map_read(map_read),
        .map_waitrequest(map_waitrequest),
        .host_req(host_req),
        .host_read(host_read),
        .host_waitrequest(host_waitrequest),
        .host_rsp(host_rsp),
        .host_readdatavalid(host_readdatavalid),
        .master_rsp(master_rsp),
        .master_readdatavalid(master_readdatavalid)
    );

endmodule

`default_nettype wire

/* rd_rob.sv */
// Read reorder buffer between the burst mapper and the host port.
// Reserves a slot range per host burst, tags the burst with its first slot
// and hands lines back to the accelerator in request order.
`timescale 1ns/1ps
`default_nettype none

module rd_rob
#(
    parameter int MAX_ACTIVE_RD_LINES = 16
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  host_mem_pkg::rd_req_t map_req,
    input  logic                  map_read,
    output logic                  map_waitrequest,
    output host_mem_pkg::rd_req_t host_req,
    output logic                  host_read,
    input  logic                  host_waitrequest,
    input  host_mem_pkg::rd_rsp_t host_rsp,
    input  logic                  host_readdatavalid,
    output host_mem_pkg::rd_rsp_t master_rsp,
    output logic                  master_readdatavalid
);
    import host_mem_pkg::*;

    // Depth is a power of two and at least one full burst of 16 lines
    localparam int IDX_W = $clog2(MAX_ACTIVE_RD_LINES);

    typedef logic [IDX_W-1:0] slot_t;
    typedef logic [IDX_W:0]   slot_cnt_t;

    // Next slot to hand out and oldest slot still owed to the accelerator
    slot_t      alloc_ptr;
    slot_t      rel_ptr;
    slot_cnt_t  free_q;

    rd_req_t    host_req_q;
    logic       host_read_q;

    slot_cnt_t  need_slots;
    logic       map_acc;
    logic       host_acc;
    logic       rel_en;
    rob_idx_t   rel_idx;
    line_data_t head_data;
    slot_t      rsp_off;
    slot_cnt_t  in_use;

    assign need_slots = slot_cnt_t'(map_req.burstcount);

    // Hold off the mapper while the host has not taken the last request,
    // or while the buffer cannot take the whole burst
    assign map_waitrequest = (host_read_q && host_waitrequest) || (free_q < need_slots);
    assign map_acc = map_read && !map_waitrequest;
    assign host_acc = host_read_q && !host_waitrequest;

    assign host_req = host_req_q;
    assign host_read = host_read_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            host_read_q <= 1'b0;
            alloc_ptr <= '0;
            rel_ptr <= '0;
            free_q <= slot_cnt_t'(MAX_ACTIVE_RD_LINES);
        end
        else
        begin
            if (map_acc)
            begin
                host_read_q <= 1'b1;
                alloc_ptr <= alloc_ptr + slot_t'(map_req.burstcount);
            end
            else if (host_acc)
            begin
                host_read_q <= 1'b0;
            end

            if (rel_en)
            begin
                rel_ptr <= rel_ptr + slot_t'(1);
            end

            // Slots come back one per release and leave a burst at a time
            free_q <= free_q + slot_cnt_t'(rel_en) - (map_acc ? need_slots : '0);
        end
    end

    // The host request carries the first reserved slot in place of the user field
    always_ff @(posedge clk)
    begin
        if (map_acc)
        begin
            host_req_q.address <= map_req.address;
            host_req_q.burstcount <= map_req.burstcount;
            host_req_q.user <= rob_idx_t'(alloc_ptr);
        end
    end

    assign rel_idx = rob_idx_t'(rel_ptr);

    // Lines land in their slot on arrival; the head drains as soon as it fills
    rd_rob_slots
    #(
        .MAX_ACTIVE_RD_LINES(MAX_ACTIVE_RD_LINES)
    )
    i_rd_rob_slots
    (
        .clk(clk),
        .reset(reset),
        .wr_en(host_readdatavalid),
        .wr_idx(host_rsp.user),
        .wr_data(host_rsp.data),
        .rd_idx(rel_idx),
        .rd_filled(rel_en),
        .rd_data(head_data),
        .clr_en(rel_en)
    );

    assign master_readdatavalid = rel_en;
    assign master_rsp = '{data: head_data, user: rel_idx};

    // Position of a returning line relative to the oldest live slot
    assign rsp_off = slot_t'(host_rsp.user) - rel_ptr;
    assign in_use = slot_cnt_t'(MAX_ACTIVE_RD_LINES) - free_q;

    // Every host line lands inside the range reserved by an issued burst
    a_rsp_slot_live: assert property (@(posedge clk) disable iff (reset)
        host_readdatavalid |->
            ((int'(host_rsp.user) < MAX_ACTIVE_RD_LINES) && (slot_cnt_t'(rsp_off) < in_use)));

    // The mapper keeps a held piece stable until this buffer takes it
    a_map_hold: assert property (@(posedge clk) disable iff (reset)
        (map_read && map_waitrequest) |=> (map_read && $stable(map_req)));

endmodule

`default_nettype wire

/* rd_rob_slots.sv */
// Slot storage of the read reorder buffer.
// Holds one response line per slot and a flag that marks the slot filled.
`timescale 1ns/1ps
`default_nettype none

module rd_rob_slots
#(
    parameter int MAX_ACTIVE_RD_LINES = 16
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  host_mem_pkg::rob_idx_t   wr_idx,
    input  host_mem_pkg::line_data_t wr_data,
    input  host_mem_pkg::rob_idx_t   rd_idx,
    output logic                     rd_filled,
    output host_mem_pkg::line_data_t rd_data,
    input  logic                     clr_en
);
    import host_mem_pkg::*;

    localparam int IDX_W = $clog2(MAX_ACTIVE_RD_LINES);

    line_data_t                     data_mem [0:MAX_ACTIVE_RD_LINES-1];
    logic [MAX_ACTIVE_RD_LINES-1:0] filled;
    logic [IDX_W-1:0]               wr_slot;
    logic [IDX_W-1:0]               rd_slot;

    // Only the low index bits address a buffer smaller than 256 lines
    assign wr_slot = wr_idx[IDX_W-1:0];
    assign rd_slot = rd_idx[IDX_W-1:0];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            data_mem[wr_slot] <= wr_data;
        end
    end

    // A write marks the slot, a release at the read index unmarks it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            filled <= '0;
        end
        else
        begin
            if (clr_en)
            begin
                filled[rd_slot] <= 1'b0;
            end
            if (wr_en)
            begin
                filled[wr_slot] <= 1'b1;
            end
        end
    end

    assign rd_filled = filled[rd_slot];
    assign rd_data = data_mem[rd_slot];

endmodule

`default_nettype wire

/* avmm_burst_map.sv */
// Splits accelerator read bursts into bursts the host memory port accepts.
// Each piece obeys the host burst limit, the page rule and, when enabled,
// natural alignment. Pieces go out in address order, one per accepted cycle.
`timescale 1ns/1ps
`default_nettype none

module avmm_burst_map
#(
    parameter int HOST_MAX_BURST = 4,
    parameter int NATURAL_ALIGNMENT = 1,
    parameter int PAGE_LINES = 8
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  host_mem_pkg::rd_req_t master_req,
    input  logic                  master_read,
    output logic                  master_waitrequest,
    output host_mem_pkg::rd_req_t map_req,
    output logic                  map_read,
    input  logic                  map_waitrequest
);
    import host_mem_pkg::*;

    // Page size for the offset math when the page rule is on
    localparam int PAGE_SZ = (PAGE_LINES == 0) ? 1 : PAGE_LINES;

    map_state_t state;
    map_state_t state_next;
    logic       wait_q;

    // Address and remaining length of the burst being split
    line_addr_t addr_q;
    burst_cnt_t rem_q;
    rob_idx_t   user_q;

    burst_cnt_t len_lim;
    line_addr_t page_room;
    burst_cnt_t piece_len;
    logic       master_acc;
    logic       piece_acc;
    logic       last_piece;

    assign master_waitrequest = wait_q;
    assign master_acc = master_read && !master_waitrequest;

    // The current piece is presented for as long as the FSM is splitting
    assign map_read = (state == SPLIT);
    assign map_req = '{address: addr_q, burstcount: piece_len, user: user_q};
    assign piece_acc = map_read && !map_waitrequest;
    assign last_piece = (piece_len == rem_q);

    // Length of the next piece by the splitting rule
    always_comb
    begin
        // Never more than what is left or what the host takes in one burst
        len_lim = (rem_q < burst_cnt_t'(HOST_MAX_BURST)) ? rem_q :
                  burst_cnt_t'(HOST_MAX_BURST);

        // Lines left before the next page boundary
        page_room = line_addr_t'(PAGE_SZ) - (addr_q & line_addr_t'(PAGE_SZ - 1));
        if ((PAGE_LINES != 0) && (page_room < line_addr_t'(len_lim)))
        begin
            len_lim = burst_cnt_t'(page_room);
        end

        if (NATURAL_ALIGNMENT != 0)
        begin
            // Largest power of two that fits and that the address is aligned to
            piece_len = burst_cnt_t'(1);
            for (int k = 1; k <= 4; k++)
            begin
                if ((burst_cnt_t'(1 << k) <= len_lim) &&
                    ((addr_q & line_addr_t'((1 << k) - 1)) == '0))
                begin
                    piece_len = burst_cnt_t'(1 << k);
                end
            end
        end
        else
        begin
            piece_len = len_lim;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (master_acc)
                begin
                    state_next = SPLIT;
                end
            end
            SPLIT:
            begin
                // Back to idle once the final piece is taken
                if (piece_acc && last_piece)
                begin
                    state_next = IDLE;
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    // Waitrequest is high out of reset and for the whole split
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            wait_q <= 1'b1;
        end
        else
        begin
            state <= state_next;
            wait_q <= (state_next == SPLIT);
        end
    end

    always_ff @(posedge clk)
    begin
        if (master_acc)
        begin
            addr_q <= master_req.address;
            rem_q <= master_req.burstcount;
            user_q <= master_req.user;
        end
        else if (piece_acc)
        begin
            addr_q <= addr_q + line_addr_t'(piece_len);
            rem_q <= rem_q - piece_len;
        end
    end

    // An accelerator burst holds between 1 and 16 lines
    a_burst_legal: assert property (@(posedge clk) disable iff (reset)
        master_read |-> ((master_req.burstcount != '0) && (master_req.burstcount <= 5'd16)));

    // A request held off by waitrequest comes back unchanged on the next cycle
    a_master_hold: assert property (@(posedge clk) disable iff (reset)
        (master_read && master_waitrequest) |=> (master_read && $stable(master_req)));

endmodule

`default_nettype wire

/* host_mem_pkg.sv */
// Shared types for the host memory read mapper.
// The burst mapper, the reorder buffer and the top level import these.
`default_nettype none

package host_mem_pkg;

    // Host memory is addressed in whole lines
    typedef logic [31:0] line_addr_t;

    // One line of read data
    typedef logic [63:0] line_data_t;

    // Burst length in lines with legal values 1 to 16
    typedef logic [4:0] burst_cnt_t;

    // Reorder buffer slot index wide enough for a 256 line buffer
    typedef logic [7:0] rob_idx_t;

    // Read request used on the accelerator side and on the host side
    // On the host side the user field carries the first reorder buffer slot
    // of the burst
    typedef struct packed {
        line_addr_t address;
        burst_cnt_t burstcount;
        rob_idx_t   user;
    } rd_req_t;

    // One response line
    // From the host the user field names the slot the line belongs to
    typedef struct packed {
        line_data_t data;
        rob_idx_t   user;
    } rd_rsp_t;

    // Burst mapper FSM states
    // IDLE waits for an accelerator burst, SPLIT issues its host pieces
    typedef enum logic {
        IDLE,
        SPLIT
    } map_state_t;

endpackage

`default_nettype wire
